//--- hdl/dense_pkg.sv
package dense_pkg;

    // neuron counts for the input and output vectors of the layer
    typedef logic [15:0] neuron_cnt_t;

    // word address, same width for both buffers
    typedef logic [15:0] buf_addr_t;

    typedef logic [15:0] block_idx_t;  // output block, N_PE neurons each

    // seq_block sits between blocks and also holds the final wait for the drain
    typedef enum logic [1:0] {
        seq_idle,
        seq_block,
        seq_run
    } seq_state_t;

    // PE pipeline latencies in cycles
    // the stage enables are spaced by these, starting from the last mac
    localparam int LAT_MAC  = 2;  // multiplier output
    localparam int LAT_ADD  = 1;  // dense accumulator
    localparam int LAT_BIAS = 1;  // bias adder
    localparam int LAT_NL   = 2;  // non-linearity, result ready for the latch

endpackage

//--- hdl/block_sequencer.sv
`timescale 1ns/10ps

module block_sequencer #(
    parameter int N_PE = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  dense_pkg::neuron_cnt_t output_len,
    input  logic                   latch_due,
    input  logic                   drain_busy,
    input  logic                   run_done,
    output logic                   block_start,
    output dense_pkg::block_idx_t  ob,
    output logic [N_PE-1:0]        pe_mask,
    output logic                   dense_latch,
    output logic                   done
);

    dense_pkg::seq_state_t  state;
    dense_pkg::seq_state_t  next_state;
    dense_pkg::block_idx_t  full_blocks;
    dense_pkg::block_idx_t  total_blocks;
    dense_pkg::neuron_cnt_t rem;
    logic                   run_seen;      // last mac of this block has gone by
    logic                   latch_pending; // latch_due came while drain was busy
    logic                   latch_ok;

    assign full_blocks  = dense_pkg::block_idx_t'(output_len / N_PE);
    assign rem          = dense_pkg::neuron_cnt_t'(output_len % N_PE);
    assign total_blocks = full_blocks + dense_pkg::block_idx_t'(rem != '0);

    // all ones, or low rem bits for the partial last block
    always_comb begin
        for (int i = 0; i < N_PE; i++) begin
            pe_mask[i] = (ob < full_blocks) || (i < rem);
        end
    end

    assign latch_ok = latch_due && run_seen;

    always_comb begin
        next_state  = state;
        dense_latch = 1'b0;
        done        = 1'b0;
        case (state)
            dense_pkg::seq_idle: begin
                if (start) next_state = dense_pkg::seq_block;
            end
            dense_pkg::seq_block: begin
                if (ob != total_blocks) begin
                    next_state = dense_pkg::seq_run;
                end else if (!drain_busy) begin  // last drain finished
                    done       = 1'b1;
                    next_state = dense_pkg::seq_idle;
                end
            end
            dense_pkg::seq_run: begin
                if ((latch_ok || latch_pending) && !drain_busy) begin
                    dense_latch = 1'b1;
                    next_state  = dense_pkg::seq_block;
                end
            end
            default: next_state = dense_pkg::seq_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= dense_pkg::seq_idle;
            ob            <= '0;
            block_start   <= 1'b0;
            run_seen      <= 1'b0;
            latch_pending <= 1'b0;
        end else begin
            state       <= next_state;
            block_start <= (state == dense_pkg::seq_block) && (next_state == dense_pkg::seq_run);

            if (state == dense_pkg::seq_idle && start) begin
                ob <= '0;
            end else if (dense_latch) begin
                ob <= ob + 1'b1;  // block handed to the drain
            end

            if (dense_latch) begin
                run_seen      <= 1'b0;
                latch_pending <= 1'b0;
            end else begin
                if (run_done) run_seen <= 1'b1;
                if (latch_ok && drain_busy) latch_pending <= 1'b1;  // defer
            end
        end
    end

endmodule

//--- hdl/operand_reader.sv
`timescale 1ns/10ps

module operand_reader #(
    parameter int N_PE = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   block_start,
    input  dense_pkg::neuron_cnt_t input_len,
    input  dense_pkg::block_idx_t  ob,
    input  logic [N_PE-1:0]        pe_mask,
    output logic [N_PE-1:0]        w_rd_en,
    output dense_pkg::buf_addr_t   w_rd_addr,
    output logic                   x_rd_en,
    output dense_pkg::buf_addr_t   x_rd_addr,
    output logic [N_PE-1:0]        shift_weight,
    output logic                   shift_input,
    output logic                   shift_bias_en,
    output logic [N_PE-1:0]        mac_enable,
    output logic                   last_mac
);

    dense_pkg::neuron_cnt_t rd_idx;
    dense_pkg::neuron_cnt_t cur_idx;
    logic                   rd_active;
    logic                   reading;
    dense_pkg::neuron_cnt_t sh_idx;   // read index, one cycle later
    logic                   sh_valid;
    dense_pkg::neuron_cnt_t mac_idx;  // and one more
    logic                   mac_valid;

    // block_start is read cycle k = 0 itself
    assign reading = block_start || rd_active;
    assign cur_idx = block_start ? '0 : rd_idx;

    // weights and bias sit in one row of in+1 words per block
    assign w_rd_en   = reading ? pe_mask : '0;
    assign w_rd_addr = dense_pkg::buf_addr_t'((input_len + 1'b1) * ob + cur_idx);
    assign x_rd_en   = reading && (cur_idx < input_len);  // no input word for the bias
    assign x_rd_addr = dense_pkg::buf_addr_t'(cur_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_active <= 1'b0;
            rd_idx    <= '0;
        end else if (reading) begin
            rd_active <= (cur_idx != input_len);
            rd_idx    <= cur_idx + 1'b1;
        end
    end

    // read data arrives one cycle after the address
    assign shift_input   = sh_valid && (sh_idx < input_len);
    assign shift_weight  = shift_input ? pe_mask : '0;
    assign shift_bias_en = sh_valid && (sh_idx == input_len);

    assign mac_enable = mac_valid ? pe_mask : '0;
    assign last_mac   = mac_valid && (mac_idx == input_len - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sh_valid  <= 1'b0;
            mac_valid <= 1'b0;
        end else begin
            sh_valid  <= reading;
            mac_valid <= shift_input;
        end
    end

    always_ff @(posedge clk) begin
        sh_idx  <= cur_idx;
        mac_idx <= sh_idx;
    end

endmodule

//--- hdl/stage_timer.sv
`timescale 1ns/10ps

module stage_timer #(
    parameter int N_PE = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            last_mac,
    input  logic [N_PE-1:0] pe_mask,
    output logic [N_PE-1:0] adder_on,
    output logic [N_PE-1:0] bias_enable,
    output logic [N_PE-1:0] nl_enable,
    output logic            latch_due
);

    // taps counted in cycles after the last mac_enable
    localparam int TAP_ADD   = dense_pkg::LAT_MAC;
    localparam int TAP_BIAS  = TAP_ADD + dense_pkg::LAT_ADD;
    localparam int TAP_NL    = TAP_BIAS + dense_pkg::LAT_BIAS;
    localparam int TAP_LATCH = TAP_NL + dense_pkg::LAT_NL;

    logic [TAP_LATCH:1] dly;  // dly[n] is last_mac from n cycles back

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dly <= '0;
        end else begin
            dly <= {dly[TAP_LATCH-1:1], last_mac};
        end
    end

    // mask is held by the sequencer until the latch, so it still fits here
    assign adder_on    = {N_PE{dly[TAP_ADD]}} & pe_mask;
    assign bias_enable = {N_PE{dly[TAP_BIAS]}} & pe_mask;
    assign nl_enable   = {N_PE{dly[TAP_NL]}} & pe_mask;
    assign latch_due   = dly[TAP_LATCH];  // PE results settled

endmodule

//--- hdl/result_drain.sv
`timescale 1ns/10ps

module result_drain #(
    parameter int N_PE = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dense_latch,
    input  dense_pkg::block_idx_t ob,
    input  logic [N_PE-1:0]       pe_mask,
    output logic                  wb_en,
    output dense_pkg::buf_addr_t  wb_addr,
    output logic [((N_PE > 1) ? $clog2(N_PE) : 1)-1:0] dense_rd_addr,
    output logic                  drain_busy
);

    localparam int PE_W  = (N_PE > 1) ? $clog2(N_PE) : 1;
    localparam int CNT_W = $clog2(N_PE + 1);

    logic [CNT_W-1:0]      act_cnt;  // PEs enabled in the latched block
    logic [CNT_W-1:0]      cnt_q;
    dense_pkg::block_idx_t ob_q;
    logic [PE_W-1:0]       rd_addr;
    logic                  last_wr;

    always_comb begin
        act_cnt = '0;
        for (int i = 0; i < N_PE; i++) begin
            act_cnt = act_cnt + CNT_W'(pe_mask[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (dense_latch) begin
            ob_q  <= ob;
            cnt_q <= act_cnt;
        end
    end

    assign last_wr = (CNT_W'(rd_addr) + 1'b1) == cnt_q;

    // one word per cycle out of the latch, starting the cycle after dense_latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_busy <= 1'b0;
            rd_addr    <= '0;
        end else if (dense_latch) begin
            drain_busy <= 1'b1;
            rd_addr    <= '0;
        end else if (drain_busy) begin
            drain_busy <= !last_wr;
            rd_addr    <= last_wr ? '0 : rd_addr + 1'b1;
        end
    end

    assign wb_en         = drain_busy;
    assign wb_addr       = dense_pkg::buf_addr_t'(ob_q * N_PE) + dense_pkg::buf_addr_t'(rd_addr);
    assign dense_rd_addr = rd_addr;

endmodule

//--- hdl/dense_top.sv
`timescale 1ns/10ps

module dense_top #(
    parameter int N_PE = 8
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start,
    input  dense_pkg::neuron_cnt_t                  input_len,
    input  dense_pkg::neuron_cnt_t                  output_len,
    output logic [N_PE-1:0]                         w_rd_en,
    output dense_pkg::buf_addr_t                    w_rd_addr,
    output logic                                    x_rd_en,
    output dense_pkg::buf_addr_t                    x_rd_addr,
    output logic [N_PE-1:0]                         shift_weight,
    output logic                                    shift_input,
    output logic                                    shift_bias_en,
    output logic [N_PE-1:0]                         mac_enable,
    output logic [N_PE-1:0]                         adder_on,
    output logic [N_PE-1:0]                         bias_enable,
    output logic [N_PE-1:0]                         nl_enable,
    output logic                                    dense_latch,
    output logic                                    wb_en,
    output dense_pkg::buf_addr_t                    wb_addr,
    output logic [((N_PE > 1) ? $clog2(N_PE) : 1)-1:0] dense_rd_addr,
    output logic                                    done
);

    logic                  block_start;
    dense_pkg::block_idx_t ob;
    logic [N_PE-1:0]       pe_mask;
    logic                  last_mac;
    logic                  latch_due;
    logic                  drain_busy;

    block_sequencer #(.N_PE(N_PE)) u_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .output_len  (output_len),
        .latch_due   (latch_due),
        .drain_busy  (drain_busy),
        .run_done    (last_mac),
        .block_start (block_start),
        .ob          (ob),
        .pe_mask     (pe_mask),
        .dense_latch (dense_latch),
        .done        (done)
    );

    operand_reader #(.N_PE(N_PE)) u_reader (
        .clk           (clk),
        .rst           (rst),
        .block_start   (block_start),
        .input_len     (input_len),
        .ob            (ob),
        .pe_mask       (pe_mask),
        .w_rd_en       (w_rd_en),
        .w_rd_addr     (w_rd_addr),
        .x_rd_en       (x_rd_en),
        .x_rd_addr     (x_rd_addr),
        .shift_weight  (shift_weight),
        .shift_input   (shift_input),
        .shift_bias_en (shift_bias_en),
        .mac_enable    (mac_enable),
        .last_mac      (last_mac)
    );

    stage_timer #(.N_PE(N_PE)) u_timer (
        .clk         (clk),
        .rst         (rst),
        .last_mac    (last_mac),
        .pe_mask     (pe_mask),
        .adder_on    (adder_on),
        .bias_enable (bias_enable),
        .nl_enable   (nl_enable),
        .latch_due   (latch_due)
    );

    result_drain #(.N_PE(N_PE)) u_drain (
        .clk           (clk),
        .rst           (rst),
        .dense_latch   (dense_latch),
        .ob            (ob),
        .pe_mask       (pe_mask),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .dense_rd_addr (dense_rd_addr),
        .drain_busy    (drain_busy)
    );

endmodule

//--- testbench/dense_assert.sv
`timescale 1ns/10ps

module dense_assert (
    input logic clk,
    input logic rst,
    input logic wb_en,
    input logic dense_latch,
    input logic drain_busy,
    input logic done
);

    // a new latch only when the previous drain has finished
    latch_vs_drain: assert property (@(posedge clk) disable iff (rst)
        !(dense_latch && drain_busy))
        else $error("dense_latch while drain still busy");

    // first write comes one cycle after the latch
    drain_start: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_en) |-> $past(dense_latch))
        else $error("write-back started without a latch");

    no_done_in_drain: assert property (@(posedge clk) disable iff (rst)
        !(done && wb_en))
        else $error("done together with wb_en");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done longer than one cycle");

endmodule

bind dense_top dense_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .wb_en       (wb_en),
    .dense_latch (dense_latch),
    .drain_busy  (drain_busy),
    .done        (done)
);

//--- testbench/dense_tb.sv
`timescale 1ns/10ps

module dense_tb;

    localparam int N_PE = 8;
    localparam logic [N_PE-1:0] FULL = {N_PE{1'b1}};

    logic clk;
    logic rst;
    logic start;
    dense_pkg::neuron_cnt_t input_len;
    dense_pkg::neuron_cnt_t output_len;
    logic [N_PE-1:0] w_rd_en, shift_weight, mac_enable, adder_on, bias_enable, nl_enable;
    dense_pkg::buf_addr_t w_rd_addr, x_rd_addr, wb_addr;
    logic x_rd_en, shift_input, shift_bias_en, dense_latch, wb_en, done;
    logic [$clog2(N_PE)-1:0] dense_rd_addr;

    // golden table
    int t_in[$], t_out[$], t_blocks[$], t_mask[$];
    int wd_limit;
    bit wd_ready;

    // monitor state
    int cyc;
    bit idle;
    int cur_in, cur_out, exp_blocks;
    logic [N_PE-1:0] exp_last_mask;
    int wb_cnt, blk_cnt, rd_k, sh_cnt, mac_cnt, latch_cnt, done_cnt;
    int bias_cnt;   // shift_bias_en strobes in this test
    logic [N_PE-1:0] blk_mask;
    int mac_cyc, add_cyc, bias_cyc, nl_cyc;
    int latch_cyc;  // cycle of the previous dense_latch
    int err_cnt;

    dense_top #(.N_PE(N_PE)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_run();
        err_cnt++;
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(string name, logic [31:0] exp_v, logic [31:0] act_v);
        assert (exp_v == act_v) else begin
            $display("[FAIL] %s expected %h actual %h at cycle %0d", name, exp_v, act_v, cyc);
            stop_run();
        end
    endtask

    task automatic check_true(bit cond, string what);
        assert (cond) else begin
            $display("%s (cycle %0d)", what, cyc);
            stop_run();
        end
    endtask

    // reads the table, skipping comment lines
    task automatic load_golden();
        int fd;
        int a, b, c, d;
        string line;
        fd = $fopen("testbench/dense_golden.txt", "r");
        check_true(fd != 0, "cannot open the golden file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d %h", a, b, c, d) == 4) begin
                    t_in.push_back(a);
                    t_out.push_back(b);
                    t_blocks.push_back(c);
                    t_mask.push_back(d);
                end
            end
        end
        $fclose(fd);
        check_true(t_in.size() > 0, "golden file holds no tests");
    endtask

    // stage enables and strobes, sampled away from the clock edge
    always @(negedge clk) begin
        if (!rst) begin
            if (idle) begin
                check_val("w_rd_en", 0, w_rd_en);
                check_val("x_rd_en", 0, x_rd_en);
                check_val("shift_input", 0, shift_input);
                check_val("shift_bias_en", 0, shift_bias_en);
                check_val("mac_enable", 0, mac_enable);
                check_val("adder_on", 0, adder_on);
                check_val("bias_enable", 0, bias_enable);
                check_val("nl_enable", 0, nl_enable);
                check_val("dense_latch", 0, dense_latch);
                check_val("wb_en", 0, wb_en);
            end
            if (w_rd_en != 0) begin
                if (rd_k == 0) begin
                    blk_cnt++;
                    blk_mask = (blk_cnt == exp_blocks) ? exp_last_mask : FULL;
                end
                check_val("w_rd_en", blk_mask, w_rd_en);
                check_val("w_rd_addr", (cur_in + 1) * (blk_cnt - 1) + rd_k, w_rd_addr);
                check_val("x_rd_en", rd_k < cur_in, x_rd_en);
                if (rd_k < cur_in) check_val("x_rd_addr", rd_k, x_rd_addr);
                rd_k = (rd_k == cur_in) ? 0 : rd_k + 1;
            end else begin
                check_true(rd_k == 0, "weight reads not on consecutive cycles");
                check_val("x_rd_en", 0, x_rd_en);
            end
            if (shift_input) begin
                check_val("shift_weight", blk_mask, shift_weight);
                sh_cnt++;
            end else begin
                check_val("shift_weight", 0, shift_weight);
            end
            if (shift_bias_en) begin
                check_val("shift_input count", cur_in, sh_cnt);
                sh_cnt = 0;
                bias_cnt++;
            end
            if (mac_enable != 0) begin
                check_val("mac_enable", blk_mask, mac_enable);
                mac_cnt++;
                mac_cyc = cyc;
            end
            if (adder_on != 0) begin
                check_val("adder_on", blk_mask, adder_on);
                check_val("mac_enable count", cur_in, mac_cnt);
                check_val("adder_on cycle", mac_cyc + dense_pkg::LAT_MAC, cyc);
                mac_cnt = 0;
                add_cyc = cyc;
            end
            if (bias_enable != 0) begin
                check_val("bias_enable", blk_mask, bias_enable);
                check_val("bias_enable cycle", add_cyc + dense_pkg::LAT_ADD, cyc);
                bias_cyc = cyc;
            end
            if (nl_enable != 0) begin
                check_val("nl_enable", blk_mask, nl_enable);
                check_val("nl_enable cycle", bias_cyc + dense_pkg::LAT_BIAS, cyc);
                nl_cyc = cyc;
            end
            if (dense_latch) begin
                check_true(nl_cyc > latch_cyc, "latch came without a non-linearity pulse");
                check_true(cyc >= nl_cyc + dense_pkg::LAT_NL,
                           "latch came before the non-linearity");
                latch_cyc = cyc;
                latch_cnt++;
            end
            if (wb_en) begin
                check_val("wb_addr", wb_cnt, wb_addr);
                check_val("dense_rd_addr", wb_cnt % N_PE, dense_rd_addr);
                wb_cnt++;
            end
            if (done) begin
                check_val("wb_en count", cur_out, wb_cnt);
                check_val("block count", exp_blocks, blk_cnt);
                check_val("dense_latch count", exp_blocks, latch_cnt);
                check_val("shift_bias_en count", exp_blocks, bias_cnt);
                done_cnt++;
                idle = 1'b1;
            end
        end
    end

    task automatic run_test(int idx);
        @(posedge clk);
        cur_in = t_in[idx];
        cur_out = t_out[idx];
        exp_blocks = t_blocks[idx];
        exp_last_mask = t_mask[idx][N_PE-1:0];
        wb_cnt = 0;
        blk_cnt = 0;
        rd_k = 0;
        sh_cnt = 0;
        bias_cnt = 0;
        mac_cnt = 0;
        latch_cnt = 0;
        idle = 1'b0;
        input_len <= dense_pkg::neuron_cnt_t'(cur_in);
        output_len <= dense_pkg::neuron_cnt_t'(cur_out);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait (done_cnt == idx + 1);
        repeat (3) @(posedge clk);
        check_val("done count", idx + 1, done_cnt);
    endtask

    initial begin
        wait (wd_ready);
        repeat (wd_limit) @(posedge clk);
        $display("timeout, the DUT never finished all tests");
        stop_run();
    end

    initial begin
        rst = 1'b1;
        start = 1'b0;
        input_len = '0;
        output_len = '0;
        cyc = 0;
        idle = 1'b1;
        done_cnt = 0;
        bias_cnt = 0;
        nl_cyc = 0;
        latch_cyc = 0;
        err_cnt = 0;
        wd_ready = 1'b0;
        load_golden();
        wd_limit = 16;
        foreach (t_in[i]) wd_limit += 8 * (t_blocks[i] * (t_in[i] + 20) + t_out[i]);
        wd_ready = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        foreach (t_in[i]) run_test(i);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "errors found");
        end
    end

endmodule

//--- vlog.f
hdl/dense_pkg.sv
hdl/block_sequencer.sv
hdl/operand_reader.sv
hdl/stage_timer.sv
hdl/result_drain.sv
hdl/dense_top.sv
testbench/dense_assert.sv
testbench/dense_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dense layer controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
        --top-module dense_tb -o dense_sim; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/dense_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator returned status $sim_status"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- testbench/dense_golden.txt
# input_len output_len expected_blocks last_block_mask(hex)
# all values in decimal except the mask
3 8 1 ff
1 1 1 01
4 20 3 0f
2 16 2 ff
5 13 2 1f
1 9 2 01
6 3 1 07
2 24 3 ff
7 31 4 7f
